/* Bender.yml */
package:
  name: stream_switch

sources:
  - rtl/stream_pkg.sv
  - rtl/stream_if.sv
  - rtl/rr_frame_arbiter.sv
  - rtl/frame_mux.sv
  - rtl/skid_buffer.sv
  - rtl/stream_switch_top.sv
  - target: test
    files:
      - tests/stream_switch_asserts.sv
      - tests/tb_stream_switch.sv

/* rtl/frame_mux.sv */
// frame-locked stream multiplexer

`timescale 1ns/1ps

module frame_mux import stream_pkg::*; #(
    parameter int DATA_WIDTH = DEF_DATA_WIDTH,
    parameter int NUM_PORTS  = DEF_NUM_PORTS
) (
    input  logic                         clk,
    input  logic                         rst,

    // source ports
    input  logic [DATA_WIDTH-1:0]        s_tdata [NUM_PORTS],
    input  logic [DATA_WIDTH/8-1:0]      s_tkeep [NUM_PORTS],
    input  logic [NUM_PORTS-1:0]         s_tvalid,
    output logic [NUM_PORTS-1:0]         s_tready,
    input  logic [NUM_PORTS-1:0]         s_tlast,
    input  logic [NUM_PORTS-1:0]         s_tuser,

    // arbiter handshake
    input  logic [$clog2(NUM_PORTS)-1:0] grant,
    input  logic                         grant_valid,
    output logic                         frame_start,

    // merged stream towards the output stage
    stream_if.source                     out
);

    localparam int KEEP_WIDTH = DATA_WIDTH / 8;
    localparam int PORT_W     = $clog2(NUM_PORTS);

    mux_state_e        state;
    mux_state_e        state_next;
    logic [PORT_W-1:0] sel;

    logic [DATA_WIDTH-1:0] sel_tdata;
    logic [KEEP_WIDTH-1:0] sel_tkeep;
    logic                  sel_tvalid;
    logic                  sel_tlast;
    logic                  sel_tuser;
    logic                  end_of_frame;

    // the locked port's beat
    assign sel_tdata  = s_tdata[sel];
    assign sel_tkeep  = s_tkeep[sel];
    assign sel_tvalid = s_tvalid[sel];
    assign sel_tlast  = s_tlast[sel];
    assign sel_tuser  = s_tuser[sel];

    // grant is latched on this same edge
    assign frame_start = (state == MUX_IDLE) && grant_valid;

    // last beat of the frame accepted by the output stage
    assign end_of_frame = (state == MUX_FRAME) && sel_tvalid && out.tready && sel_tlast;

    always_comb begin
        state_next = state;
        case (state)
            MUX_IDLE: begin
                if (grant_valid) begin
                    state_next = MUX_FRAME;
                end
            end
            MUX_FRAME: begin
                if (end_of_frame) begin
                    state_next = MUX_IDLE;
                end
            end
            default: begin
                state_next = MUX_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= MUX_IDLE;
            sel   <= '0;
        end else begin
            state <= state_next;
            if (frame_start) begin
                sel <= grant;
            end
        end
    end

    // only the locked port sees ready, and only inside a frame
    always_comb begin
        s_tready = '0;
        if (state == MUX_FRAME) begin
            s_tready[sel] = out.tready;
        end
    end

    // payload passes straight through
    assign out.tdata  = sel_tdata;
    assign out.tkeep  = sel_tkeep;
    assign out.tvalid = (state == MUX_FRAME) && sel_tvalid;
    assign out.tlast  = sel_tlast;
    assign out.tuser  = sel_tuser;

endmodule

/* rtl/rr_frame_arbiter.sv */
// round-robin frame arbiter

`timescale 1ns/1ps

module rr_frame_arbiter import stream_pkg::*; #(
    parameter int NUM_PORTS = DEF_NUM_PORTS
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [NUM_PORTS-1:0]         req,
    input  logic                         frame_start,
    output logic [$clog2(NUM_PORTS)-1:0] grant,
    output logic                         grant_valid
);

    localparam int PORT_W = $clog2(NUM_PORTS);

    // port that started the most recent frame
    logic [PORT_W-1:0] last_port;

    // rotating search starting one past last_port
    // walk the offsets downward so the nearest requester is the one kept
    always_comb begin
        int unsigned idx;

        grant       = last_port;
        grant_valid = 1'b0;
        for (int i = NUM_PORTS; i >= 1; i--) begin
            idx = int'(last_port) + i;
            if (idx >= NUM_PORTS) begin
                idx = idx - NUM_PORTS;
            end
            if (req[idx]) begin
                grant       = PORT_W'(idx);
                grant_valid = 1'b1;
            end
        end
    end

    // pointer moves only when the mux actually takes the grant
    // resets to the last port so port 0 is first in line
    always_ff @(posedge clk) begin
        if (rst) begin
            last_port <= PORT_W'(NUM_PORTS - 1);
        end else if (frame_start) begin
            last_port <= grant;
        end
    end

endmodule

/* rtl/skid_buffer.sv */
// two-register output skid buffer

`timescale 1ns/1ps

module skid_buffer import stream_pkg::*; #(
    parameter int DATA_WIDTH = DEF_DATA_WIDTH
) (
    input  logic                    clk,
    input  logic                    rst,
    stream_if.sink                  in,
    output logic [DATA_WIDTH-1:0]   m_tdata,
    output logic [DATA_WIDTH/8-1:0] m_tkeep,
    output logic                    m_tvalid,
    input  logic                    m_tready,
    output logic                    m_tlast,
    output logic                    m_tuser
);

    localparam int KEEP_WIDTH = DATA_WIDTH / 8;

    // spare register, filled when a beat lands while the output is held
    logic [DATA_WIDTH-1:0] spare_tdata;
    logic [KEEP_WIDTH-1:0] spare_tkeep;
    logic                  spare_tlast;
    logic                  spare_tuser;
    logic                  spare_valid;

    logic in_ready;
    logic accept;
    logic out_free;

    assign in.tready = in_ready;
    assign accept    = in.tvalid && in_ready;
    // output register can take a new beat this edge
    assign out_free  = m_tready || !m_tvalid;

    always_ff @(posedge clk) begin
        if (rst) begin
            m_tvalid    <= 1'b0;
            spare_valid <= 1'b0;
            in_ready    <= 1'b0;
        end else begin
            if (out_free) begin
                // in_ready implies an empty spare, so both never load at once
                m_tvalid    <= spare_valid || accept;
                spare_valid <= 1'b0;
                in_ready    <= 1'b1;
            end else if (accept) begin
                spare_valid <= 1'b1;
                in_ready    <= 1'b0;
            end else begin
                in_ready    <= !spare_valid;
            end
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (out_free) begin
            if (spare_valid) begin
                m_tdata <= spare_tdata;
                m_tkeep <= spare_tkeep;
                m_tlast <= spare_tlast;
                m_tuser <= spare_tuser;
            end else if (accept) begin
                m_tdata <= in.tdata;
                m_tkeep <= in.tkeep;
                m_tlast <= in.tlast;
                m_tuser <= in.tuser;
            end
        end else if (accept) begin
            spare_tdata <= in.tdata;
            spare_tkeep <= in.tkeep;
            spare_tlast <= in.tlast;
            spare_tuser <= in.tuser;
        end
    end

endmodule

/* rtl/stream_if.sv */
// valid/ready stream interface

`timescale 1ns/1ps

interface stream_if import stream_pkg::*; #(
    parameter int DATA_WIDTH = DEF_DATA_WIDTH
);

    localparam int KEEP_WIDTH = DATA_WIDTH / 8;

    logic [DATA_WIDTH-1:0] tdata;
    logic [KEEP_WIDTH-1:0] tkeep;
    logic                  tvalid;
    logic                  tready;
    logic                  tlast;
    logic                  tuser;

    // the side that produces beats
    modport source (
        output tdata,
        output tkeep,
        output tvalid,
        output tlast,
        output tuser,
        input  tready
    );

    // the side that consumes beats
    modport sink (
        input  tdata,
        input  tkeep,
        input  tvalid,
        input  tlast,
        input  tuser,
        output tready
    );

endinterface

/* rtl/stream_pkg.sv */
// stream switch shared definitions

package stream_pkg;

    // default datapath width in bits, a multiple of 8
    localparam int DEF_DATA_WIDTH = 64;

    // default number of source ports
    localparam int DEF_NUM_PORTS = 4;

    // frame multiplexer state
    // idle waits for a granted port to raise valid,
    // frame stays locked on that port until its tlast beat is accepted
    typedef enum logic [0:0] {
        MUX_IDLE  = 1'b0,
        MUX_FRAME = 1'b1
    } mux_state_e;

endpackage

/* rtl/stream_switch_top.sv */
// four-port stream packet switch

`timescale 1ns/1ps

module stream_switch_top import stream_pkg::*; #(
    parameter int DATA_WIDTH = DEF_DATA_WIDTH,
    parameter int NUM_PORTS  = DEF_NUM_PORTS
) (
    input  logic                    clk,
    input  logic                    rst,

    // source ports
    input  logic [DATA_WIDTH-1:0]   s_tdata [NUM_PORTS],
    input  logic [DATA_WIDTH/8-1:0] s_tkeep [NUM_PORTS],
    input  logic [NUM_PORTS-1:0]    s_tvalid,
    output logic [NUM_PORTS-1:0]    s_tready,
    input  logic [NUM_PORTS-1:0]    s_tlast,
    input  logic [NUM_PORTS-1:0]    s_tuser,

    // merged output stream
    output logic [DATA_WIDTH-1:0]   m_tdata,
    output logic [DATA_WIDTH/8-1:0] m_tkeep,
    output logic                    m_tvalid,
    input  logic                    m_tready,
    output logic                    m_tlast,
    output logic                    m_tuser
);

    localparam int PORT_W = $clog2(NUM_PORTS);

    logic [PORT_W-1:0] grant;
    logic              grant_valid;
    logic              frame_start;

    stream_if #(.DATA_WIDTH(DATA_WIDTH)) mux_out ();

    rr_frame_arbiter #(
        .NUM_PORTS   (NUM_PORTS)
    ) u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .req         (s_tvalid),
        .frame_start (frame_start),
        .grant       (grant),
        .grant_valid (grant_valid)
    );

    frame_mux #(
        .DATA_WIDTH  (DATA_WIDTH),
        .NUM_PORTS   (NUM_PORTS)
    ) u_mux (
        .clk         (clk),
        .rst         (rst),
        .s_tdata     (s_tdata),
        .s_tkeep     (s_tkeep),
        .s_tvalid    (s_tvalid),
        .s_tready    (s_tready),
        .s_tlast     (s_tlast),
        .s_tuser     (s_tuser),
        .grant       (grant),
        .grant_valid (grant_valid),
        .frame_start (frame_start),
        .out         (mux_out.source)
    );

    skid_buffer #(
        .DATA_WIDTH  (DATA_WIDTH)
    ) u_skid (
        .clk         (clk),
        .rst         (rst),
        .in          (mux_out.sink),
        .m_tdata     (m_tdata),
        .m_tkeep     (m_tkeep),
        .m_tvalid    (m_tvalid),
        .m_tready    (m_tready),
        .m_tlast     (m_tlast),
        .m_tuser     (m_tuser)
    );

endmodule

/* tb.f */
rtl/stream_pkg.sv
rtl/stream_if.sv
rtl/rr_frame_arbiter.sv
rtl/frame_mux.sv
rtl/skid_buffer.sv
rtl/stream_switch_top.sv
tests/stream_switch_asserts.sv
tests/tb_stream_switch.sv

/* tests/stream_switch_asserts.sv */
// frame mux protocol checks

`timescale 1ns/1ps

module stream_switch_asserts import stream_pkg::*; #(
    parameter int DATA_WIDTH = DEF_DATA_WIDTH,
    parameter int NUM_PORTS  = DEF_NUM_PORTS
) (
    input logic                         clk,
    input logic                         rst,
    input mux_state_e                   state,
    input logic [$clog2(NUM_PORTS)-1:0] sel,
    input logic [NUM_PORTS-1:0]         s_tready,
    input logic                         sel_tvalid,
    input logic [DATA_WIDTH-1:0]        sel_tdata,
    input logic                         sel_tlast
);

    // only the locked port may be ready
    one_ready: assert property (@(posedge clk) disable iff (rst) $onehot0(s_tready))
        else $error("more than one s_tready high");

    // a stalled beat holds until it is taken
    stall_stable: assert property (@(posedge clk) disable iff (rst)
        (state == MUX_FRAME && sel_tvalid && s_tready == '0)
        |=> (state == MUX_FRAME && sel_tvalid && $stable(sel_tdata) && $stable(sel_tlast)
             && $stable(sel)))
        else $error("mux output changed while stalled");

    idle_not_ready: assert property (@(posedge clk) disable iff (rst)
        (state == MUX_IDLE) |-> (s_tready == '0))
        else $error("s_tready high while mux idle");

endmodule

bind frame_mux stream_switch_asserts #(
    .DATA_WIDTH (DATA_WIDTH),
    .NUM_PORTS  (NUM_PORTS)
) u_asserts (
    .clk        (clk),
    .rst        (rst),
    .state      (state),
    .sel        (sel),
    .s_tready   (s_tready),
    .sel_tvalid (sel_tvalid),
    .sel_tdata  (sel_tdata),
    .sel_tlast  (sel_tlast)
);

/* tests/tb_stream_switch.sv */
// stream switch testbench

`timescale 1ns/1ps

module tb_stream_switch import stream_pkg::*; #(
    parameter int DATA_WIDTH = DEF_DATA_WIDTH,
    parameter int NUM_PORTS  = DEF_NUM_PORTS
);

    localparam int TOTAL_FRAMES = 4 * 6 + 2 * 8 + 4 * 6;
    // nine beats at most per frame, forty cycles each, 4 ns period
    localparam int LIMIT_NS     = TOTAL_FRAMES * 9 * 40 * 4 + 100;

    logic                    clk = 1'b0;
    logic                    rst;
    logic [DATA_WIDTH-1:0]   s_tdata [NUM_PORTS];
    logic [DATA_WIDTH/8-1:0] s_tkeep [NUM_PORTS];
    logic [NUM_PORTS-1:0]    s_tvalid;
    logic [NUM_PORTS-1:0]    s_tready;
    logic [NUM_PORTS-1:0]    s_tlast;
    logic [NUM_PORTS-1:0]    s_tuser;
    logic [DATA_WIDTH-1:0]   m_tdata;
    logic [DATA_WIDTH/8-1:0] m_tkeep;
    logic                    m_tvalid;
    logic                    m_tready;
    logic                    m_tlast;
    logic                    m_tuser;

    logic [31:0] rand_state = 32'hbef5;
    bit          ready_random;
    bit          rr_check;
    logic [3:0]  active_mask;
    int          last_src = NUM_PORTS - 1;
    int          frame_cnt [NUM_PORTS];
    int          rx_frame [NUM_PORTS];
    int          sent_len [NUM_PORTS][$];
    int          tx_frames;
    int          rx_frames;

    // comparator state for the frame on the output
    bit          in_frame;
    int          cur_port;
    int          cur_frame;
    int          cur_beat;
    int          cur_len;

    stream_switch_top #(
        .DATA_WIDTH (DATA_WIDTH),
        .NUM_PORTS  (NUM_PORTS)
    ) u_dut (
        .clk      (clk),
        .rst      (rst),
        .s_tdata  (s_tdata),
        .s_tkeep  (s_tkeep),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .s_tlast  (s_tlast),
        .s_tuser  (s_tuser),
        .m_tdata  (m_tdata),
        .m_tkeep  (m_tkeep),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .m_tlast  (m_tlast),
        .m_tuser  (m_tuser)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rand_state = xorshift32(rand_state);
        return rand_state;
    endfunction

    // port in the top byte, frame number below it, then the beat index
    function automatic logic [63:0] expected_beat(input int p, input int f, input int b);
        logic [31:0] mix;
        mix = (32'(f) * 32'h9e3779b1) ^ (32'(b) * 32'h85ebca6b) ^ 32'(p);
        return {8'(p), 16'(f), 8'(b), mix};
    endfunction

    function automatic logic [7:0] expected_keep(input int p, input int f, input bit last);
        return last ? (8'h7f >> ((p + f) % 7)) : 8'hff;
    endfunction

    function automatic bit expected_user(input int f);
        return (f % 5) == 4;
    endfunction

    // next port in rotating order among the active ones
    function automatic int next_port(input int last, input logic [3:0] mask);
        int c;
        for (int i = 1; i <= NUM_PORTS; i++) begin
            c = (last + i) % NUM_PORTS;
            if (mask[c]) begin
                return c;
            end
        end
        return -1;
    endfunction

    task automatic flag_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic stop_on_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // one source port; holds valid across frames when saturated
    task automatic run_port(input int p, input int n_frames, input bit idle_gaps);
        int len;
        int gap;
        for (int f = 0; f < n_frames; f++) begin
            len = 1 + int'(next_rand() % 9);
            sent_len[p].push_back(len);
            if (idle_gaps) begin
                gap = int'(next_rand() % 4);
                if (gap > 0) begin
                    s_tvalid[p] = 1'b0;
                    repeat (gap) begin
                        @(posedge clk);
                        #1;
                    end
                end
            end
            for (int b = 0; b < len; b++) begin
                gap = (b > 0 && next_rand() % 4 == 0) ? 1 + int'(next_rand() % 2) : 0;
                if (gap > 0) begin
                    s_tvalid[p] = 1'b0;
                    repeat (gap) begin
                        @(posedge clk);
                        #1;
                    end
                end
                s_tdata[p]  = expected_beat(p, frame_cnt[p], b);
                s_tkeep[p]  = expected_keep(p, frame_cnt[p], b == len - 1);
                s_tlast[p]  = (b == len - 1);
                s_tuser[p]  = expected_user(frame_cnt[p]);
                s_tvalid[p] = 1'b1;
                do @(posedge clk); while (!s_tready[p]);
                #1;
            end
            frame_cnt[p]++;
            tx_frames++;
        end
        s_tvalid[p] = 1'b0;
    endtask

    task automatic run_phase(input logic [3:0] mask, input int n_frames,
                             input bit rand_ready, input bit gaps);
        active_mask  = mask;
        ready_random = rand_ready;
        rr_check     = !gaps;
        fork
            if (mask[0]) run_port(0, n_frames, gaps);
            if (mask[1]) run_port(1, n_frames, gaps);
            if (mask[2]) run_port(2, n_frames, gaps);
            if (mask[3]) run_port(3, n_frames, gaps);
        join
        wait (rx_frames == tx_frames);
        @(posedge clk);
        #1;
    endtask

    // sink with optional back-pressure
    always @(posedge clk) begin
        #1;
        m_tready = ready_random ? (next_rand() % 2 == 1) : 1'b1;
    end

    always @(posedge clk) begin
        int p;
        int f;
        if (!rst && m_tvalid && m_tready) begin
            if (!in_frame) begin
                p = int'(m_tdata[63:56]);
                f = int'(m_tdata[55:40]);
                assert (p < NUM_PORTS && sent_len[p].size() > 0)
                    else stop_on_error("output frame from a port with nothing pending");
                assert (f == rx_frame[p])
                    else flag_mismatch("frame_no", 64'(f), 64'(rx_frame[p]));
                if (rr_check) begin
                    assert (p == next_port(last_src, active_mask))
                        else flag_mismatch("source port", 64'(p),
                                           64'(next_port(last_src, active_mask)));
                end
                last_src  = p;
                cur_port  = p;
                cur_frame = f;
                cur_beat  = 0;
                cur_len   = sent_len[p].pop_front();
                in_frame  = 1'b1;
            end
            assert (m_tdata == expected_beat(cur_port, cur_frame, cur_beat))
                else flag_mismatch("m_tdata", m_tdata, expected_beat(cur_port, cur_frame,
                                   cur_beat));
            assert (m_tkeep == expected_keep(cur_port, cur_frame, cur_beat == cur_len - 1))
                else flag_mismatch("m_tkeep", 64'(m_tkeep),
                                   64'(expected_keep(cur_port, cur_frame,
                                                     cur_beat == cur_len - 1)));
            assert (m_tlast == (cur_beat == cur_len - 1))
                else flag_mismatch("m_tlast", 64'(m_tlast), 64'(cur_beat == cur_len - 1));
            assert (m_tuser == expected_user(cur_frame))
                else flag_mismatch("m_tuser", 64'(m_tuser), 64'(expected_user(cur_frame)));
            cur_beat++;
            if (m_tlast) begin
                in_frame = 1'b0;
                rx_frame[cur_port]++;
                rx_frames++;
            end
        end
    end

    initial begin
        #(LIMIT_NS);
        $display("Error: timeout, the switch stopped delivering frames");
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst          = 1'b1;
        m_tready     = 1'b0;
        s_tvalid     = '0;
        s_tlast      = '0;
        s_tuser      = '0;
        ready_random = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            s_tdata[p]   = '0;
            s_tkeep[p]   = '0;
            frame_cnt[p] = 0;
            rx_frame[p]  = 0;
        end
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            #1;
            assert (m_tvalid == 1'b0 && s_tready == '0)
                else stop_on_error("outputs not idle during or right after reset");
            rst = 1'b0;
            if (i < 2) begin
                rst = 1'b1;
            end
        end
        // all ports saturated, then ports 1 and 3, then idle gaps
        run_phase(4'b1111, 6, 1'b1, 1'b0);
        run_phase(4'b1010, 8, 1'b1, 1'b0);
        run_phase(4'b1111, 6, 1'b0, 1'b1);
        for (int p = 0; p < NUM_PORTS; p++) begin
            assert (sent_len[p].size() == 0 && rx_frame[p] == frame_cnt[p])
                else stop_on_error("a sent frame was never received");
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule
